//--- logic/arb_macros.svh
// shared-target arbiter configuration
// number of requesters and the bus widths used by the packages
// edit the values below to build other configurations

`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// number of requesters competing for the target
// any value of one or more works, powers of two are not required
`define ARB_NUM_PORTS 4

// width of the target address
`define BUS_ADDR_W 8

// width of the write and read data words
`define BUS_DATA_W 16

`endif

//--- logic/arb_cfg_pkg.sv
// arbitration configuration types
// sizes the requester index and the per-requester bit vector
// from the port count in the macro header

`default_nettype none

`include "arb_macros.svh"

package arb_cfg_pkg;

  // number of requesters seen by the arbitration tree
  localparam int unsigned NumPorts = `ARB_NUM_PORTS;

  // index width, kept at one bit for the single-port case
  localparam int unsigned IdxW = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  // requester index, also the round-robin priority value
  typedef logic [IdxW-1:0] port_idx_t;

  // one bit per requester for requests, grants and response strobes
  typedef logic [NumPorts-1:0] port_vec_t;

endpackage

`default_nettype wire

//--- logic/bus_pkg.sv
// target bus types
// command and response structs shared by the requesters,
// the arbiter and the external target

`default_nettype none

`include "arb_macros.svh"

package bus_pkg;

  localparam int unsigned AddrW = `BUS_ADDR_W;
  localparam int unsigned DataW = `BUS_DATA_W;

  typedef logic [AddrW-1:0] bus_addr_t;
  typedef logic [DataW-1:0] bus_data_t;

  // one target access, wdata is ignored by the target on a read
  typedef struct packed {
    logic      we;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_cmd_t;

  // response back to the requesters
  // valid strobes the bit of the port that issued the access
  typedef struct packed {
    arb_cfg_pkg::port_vec_t valid;
    bus_data_t              rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- logic/lzc.sv
// trailing-zero counter
// finds the lowest set bit of a request vector with a balanced
// binary tree, empty_o flags an all-zero input and cnt_o is then
// not meaningful

`timescale 1ns/100ps
`default_nettype none

module lzc (
  input  arb_cfg_pkg::port_vec_t in_i,
  output arb_cfg_pkg::port_idx_t cnt_o,
  output logic                   empty_o
);

  import arb_cfg_pkg::*;

  localparam int unsigned NumLevels = IdxW;
  localparam int unsigned PadW      = 2 ** NumLevels;

  // input padded up to a full tree, missing leaves read as zero
  logic      [PadW-1:0] in_pad;
  logic      [PadW-2:0] vld_nodes;
  port_idx_t [PadW-2:0] idx_nodes;

  always_comb begin
    in_pad = '0;
    in_pad[NumPorts-1:0] = in_i;
  end

  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar n = 0; n < 2 ** level; n++) begin : gen_nodes
      localparam int unsigned Node  = 2 ** level - 1 + n;
      localparam int unsigned Child = 2 ** (level + 1) - 1 + 2 * n;
      if (level == NumLevels - 1) begin : gen_leaf
        // leaf looks at two input bits, the lower one wins
        assign vld_nodes[Node] = in_pad[2*n] | in_pad[2*n+1];
        assign idx_nodes[Node] = port_idx_t'(~in_pad[2*n]);
      end else begin : gen_inner
        // prefer the lower subtree, prepend the branch taken as the next index bit
        assign vld_nodes[Node] = vld_nodes[Child] | vld_nodes[Child+1];
        assign idx_nodes[Node] = vld_nodes[Child] ?
          port_idx_t'({1'b0, idx_nodes[Child][NumLevels-level-2:0]}) :
          port_idx_t'({1'b1, idx_nodes[Child+1][NumLevels-level-2:0]});
      end
    end
  end

  assign cnt_o   = idx_nodes[0];
  assign empty_o = ~vld_nodes[0];

endmodule

`default_nettype wire

//--- logic/rr_arb_tree.sv
// round-robin arbitration tree
// a logarithmic tree of two-way selectors picks one requester per
// cycle, the command and index travel up and the grant travels down
// a priority register rotates on every accepted transfer, either by
// one or, with FairArb, to the next requesting index above the last

`timescale 1ns/100ps
`default_nettype none

module rr_arb_tree #(
  parameter bit FairArb = 1'b1
) (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  arb_cfg_pkg::port_vec_t                             req_i,
  input  bus_pkg::bus_cmd_t [arb_cfg_pkg::NumPorts-1:0]      cmd_i,
  output arb_cfg_pkg::port_vec_t                             gnt_o,
  output logic                                               req_o,
  output bus_pkg::bus_cmd_t                                  cmd_o,
  output arb_cfg_pkg::port_idx_t                             idx_o,
  input  logic                                               gnt_i
);

  import arb_cfg_pkg::*;
  import bus_pkg::*;

  localparam int unsigned NumLevels = IdxW;
  localparam int unsigned NumNodes  = 2 ** NumLevels - 1;

  // node 0 is the root, the children of node k are 2k+1 and 2k+2
  logic      [NumNodes-1:0] req_nodes;
  logic      [NumNodes-1:0] gnt_nodes;
  port_idx_t [NumNodes-1:0] idx_nodes;
  bus_cmd_t  [NumNodes-1:0] cmd_nodes;

  // highest priority requester for the current cycle
  port_idx_t rr_q;
  port_idx_t rr_d;

  ////////////////////////////////////////////////////////////////////////////
  // priority update
  ////////////////////////////////////////////////////////////////////////////

  if (FairArb) begin : gen_fair
    port_vec_t upper_mask;
    port_vec_t lower_mask;
    port_idx_t upper_idx;
    port_idx_t lower_idx;
    logic      upper_empty;
    logic      lower_empty;
    port_idx_t next_idx;

    // split the requests into those above the current priority and the rest
    for (genvar i = 0; i < NumPorts; i++) begin : gen_mask
      assign upper_mask[i] = (port_idx_t'(i) >  rr_q) ? req_i[i] : 1'b0;
      assign lower_mask[i] = (port_idx_t'(i) <= rr_q) ? req_i[i] : 1'b0;
    end

    lzc upper_lzc_inst (
      .in_i    (upper_mask),
      .cnt_o   (upper_idx),
      .empty_o (upper_empty)
    );

    lzc lower_lzc_inst (
      .in_i    (lower_mask),
      .cnt_o   (lower_idx),
      .empty_o (lower_empty)
    );

    // nothing above the priority means the search wraps to the lower half
    assign next_idx = !upper_empty ? upper_idx :
                      !lower_empty ? lower_idx : rr_q;
    assign rr_d     = (gnt_i && req_o) ? next_idx : rr_q;
  end else begin : gen_simple
    // plain rotation, blind to which ports are actually requesting
    assign rr_d = (gnt_i && req_o) ?
                  ((rr_q == port_idx_t'(NumPorts - 1)) ? '0 : rr_q + 1'b1) : rr_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // selector tree
  ////////////////////////////////////////////////////////////////////////////

  assign gnt_nodes[0] = gnt_i;

  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar n = 0; n < 2 ** level; n++) begin : gen_nodes
      localparam int unsigned Node  = 2 ** level - 1 + n;
      localparam int unsigned Child = 2 ** (level + 1) - 1 + 2 * n;
      if (level == NumLevels - 1) begin : gen_leaf
        if (2 * n < NumPorts - 1) begin : gen_pair
          logic sel;
          // take the odd port if the even one is idle or the priority bit points at it
          assign sel = ~req_i[2*n] | (req_i[2*n+1] & rr_q[NumLevels-1-level]);
          assign req_nodes[Node] = req_i[2*n] | req_i[2*n+1];
          assign idx_nodes[Node] = port_idx_t'(sel);
          assign cmd_nodes[Node] = sel ? cmd_i[2*n+1] : cmd_i[2*n];
          assign gnt_o[2*n]      = gnt_nodes[Node] & req_i[2*n] & ~sel;
          assign gnt_o[2*n+1]    = gnt_nodes[Node] & req_i[2*n+1] & sel;
        end else if (2 * n == NumPorts - 1) begin : gen_single
          // odd port count leaves one port without a partner
          assign req_nodes[Node] = req_i[2*n];
          assign idx_nodes[Node] = '0;
          assign cmd_nodes[Node] = cmd_i[2*n];
          assign gnt_o[2*n]      = gnt_nodes[Node] & req_i[2*n];
        end else begin : gen_unused
          assign req_nodes[Node] = 1'b0;
          assign idx_nodes[Node] = '0;
          assign cmd_nodes[Node] = '0;
        end
      end else begin : gen_inner
        logic sel;
        assign sel = ~req_nodes[Child] | (req_nodes[Child+1] & rr_q[NumLevels-1-level]);
        assign req_nodes[Node] = req_nodes[Child] | req_nodes[Child+1];
        // the branch taken becomes the next higher index bit
        assign idx_nodes[Node] = sel ?
          port_idx_t'({1'b1, idx_nodes[Child+1][NumLevels-level-2:0]}) :
          port_idx_t'({1'b0, idx_nodes[Child][NumLevels-level-2:0]});
        assign cmd_nodes[Node]    = sel ? cmd_nodes[Child+1] : cmd_nodes[Child];
        assign gnt_nodes[Child]   = gnt_nodes[Node] & ~sel;
        assign gnt_nodes[Child+1] = gnt_nodes[Node] & sel;
      end
    end
  end

  // the root carries the decision of the whole tree
  assign req_o = req_nodes[0];
  assign cmd_o = cmd_nodes[0];
  assign idx_o = idx_nodes[0];

endmodule

`default_nettype wire

//--- logic/fourphase_port.sv
// four-phase target port
// takes one granted command at a time and runs it to the target as
// req up, ack up, req down, ack down, then strobes the read data
// back to the requester that won the grant

`timescale 1ns/100ps
`default_nettype none

module fourphase_port (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  bus_pkg::bus_cmd_t      cmd_i,
  input  arb_cfg_pkg::port_idx_t idx_i,
  output logic                   gnt_o,
  output logic                   tgt_req_o,
  output bus_pkg::bus_cmd_t      tgt_cmd_o,
  input  logic                   tgt_ack_i,
  input  bus_pkg::bus_data_t     tgt_rdata_i,
  output bus_pkg::bus_rsp_t      rsp_o
);

  import arb_cfg_pkg::*;
  import bus_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StReq,
    StResp,
    StWaitLow
  } state_e;

  state_e    state_q;
  state_e    state_d;

  // command, winner and read data of the access in flight
  bus_cmd_t  cmd_q;
  port_idx_t idx_q;
  bus_data_t rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // handshake sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: begin
        if (req_i) begin
          state_d = StReq;
        end
      end
      // hold req until the target acknowledges
      StReq: begin
        if (tgt_ack_i) begin
          state_d = StResp;
        end
      end
      // req is already low here, a target that drops ack at once skips the wait
      StResp: begin
        state_d = tgt_ack_i ? StWaitLow : StIdle;
      end
      StWaitLow: begin
        if (!tgt_ack_i) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // the command is held from the grant until the port is idle again
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && req_i) begin
      cmd_q <= cmd_i;
      idx_q <= idx_i;
    end
    if (state_q == StReq && tgt_ack_i) begin
      rdata_q <= tgt_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  // only an idle port accepts a new command
  assign gnt_o     = (state_q == StIdle);
  assign tgt_req_o = (state_q == StReq);
  assign tgt_cmd_o = cmd_q;

  // one-cycle strobe on the stored winner
  assign rsp_o.valid = (state_q == StResp) ? (port_vec_t'(1'b1) << idx_q) : '0;
  assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- logic/arb_top.sv
// shared-target access arbiter
// four requesters share one slow target through a fair round-robin
// tree feeding a four-phase req/ack target port

`timescale 1ns/100ps
`default_nettype none

module arb_top (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  arb_cfg_pkg::port_vec_t                         port_req_i,
  input  bus_pkg::bus_cmd_t [arb_cfg_pkg::NumPorts-1:0]  port_cmd_i,
  output arb_cfg_pkg::port_vec_t                         port_gnt_o,
  output bus_pkg::bus_rsp_t                              rsp_o,
  output logic                                           tgt_req_o,
  output bus_pkg::bus_cmd_t                              tgt_cmd_o,
  input  logic                                           tgt_ack_i,
  input  bus_pkg::bus_data_t                             tgt_rdata_i
);

  import arb_cfg_pkg::*;
  import bus_pkg::*;

  // winning request between tree and target port
  logic      arb_req;
  bus_cmd_t  arb_cmd;
  port_idx_t arb_idx;
  logic      arb_gnt;

  rr_arb_tree #(
    .FairArb (1'b1)
  ) tree_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (port_req_i),
    .cmd_i  (port_cmd_i),
    .gnt_o  (port_gnt_o),
    .req_o  (arb_req),
    .cmd_o  (arb_cmd),
    .idx_o  (arb_idx),
    .gnt_i  (arb_gnt)
  );

  fourphase_port port_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (arb_req),
    .cmd_i       (arb_cmd),
    .idx_i       (arb_idx),
    .gnt_o       (arb_gnt),
    .tgt_req_o   (tgt_req_o),
    .tgt_cmd_o   (tgt_cmd_o),
    .tgt_ack_i   (tgt_ack_i),
    .tgt_rdata_i (tgt_rdata_i),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

//--- test/arb_assertions.sv
// protocol checks for the shared-target arbiter
// bound into arb_top, covers the grant rules on the requester side
// and the four-phase req/ack sequence on the target side

`timescale 1ns/100ps
`default_nettype none

module arb_assertions (
  input logic                   clk_i,
  input logic                   rst_ni,
  input arb_cfg_pkg::port_vec_t port_req_i,
  input arb_cfg_pkg::port_vec_t port_gnt_i,
  input bus_pkg::bus_rsp_t      rsp_i,
  input logic                   tgt_req_i,
  input bus_pkg::bus_cmd_t      tgt_cmd_i,
  input logic                   tgt_ack_i
);

  // number of failed checks, read by the testbench at the end of each test
  int unsigned fail_cnt = 0;

  // ack as it was at the previous edge
  logic ack_q;
  // the port is busy from its request until one cycle after ack is seen low
  logic port_busy;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= tgt_ack_i;
    end
  end

  assign port_busy = tgt_req_i | tgt_ack_i | ack_q | (|rsp_i.valid);

  ////////////////////////////////////////////////////////////////////////////
  // requester side
  ////////////////////////////////////////////////////////////////////////////

  // at most one requester owns the target port in any cycle
  gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(port_gnt_i))
  else begin
    fail_cnt++;
    $error("more than one grant bit is high");
  end

  // a busy port never hands out a grant
  gnt_only_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |port_gnt_i |-> !port_busy)
  else begin
    fail_cnt++;
    $error("grant given while the target port is busy");
  end

  // an idle port with a pending request grants in the same cycle
  gnt_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!port_busy && |port_req_i) |-> |port_gnt_i)
  else begin
    fail_cnt++;
    $error("idle port with a pending request gave no grant");
  end

  ////////////////////////////////////////////////////////////////////////////
  // target side
  ////////////////////////////////////////////////////////////////////////////

  // a new access starts only after the previous ack has gone low
  req_rise_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(tgt_req_i) |-> !tgt_ack_i)
  else begin
    fail_cnt++;
    $error("target request rose while ack was still high");
  end

  req_fall_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(tgt_req_i) |-> $past(tgt_ack_i))
  else begin
    fail_cnt++;
    $error("target request dropped before the ack");
  end

  // the command may change only in the cycle the request first rises
  cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((tgt_req_i || tgt_ack_i) && $past(tgt_req_i || tgt_ack_i)) |-> $stable(tgt_cmd_i))
  else begin
    fail_cnt++;
    $error("target command changed during a handshake");
  end

endmodule

`default_nettype wire

//--- test/tb_arb_top.sv
// testbench for the shared-target arbiter
// drives four requesters through reset, saturation and sparse traffic
// against a memory target with a random ack delay
// grant order and read data are checked against a local model,
// protocol rules by the bound assertion module

`timescale 1ns/100ps
`default_nettype none

module tb_arb_top;

  import arb_cfg_pkg::*;
  import bus_pkg::*;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned NumTests  = 3;
  localparam int unsigned MemWords  = 2 ** AddrW;

  logic                    clk;
  logic                    rst_n;
  port_vec_t               port_req;
  bus_cmd_t [NumPorts-1:0] port_cmd;
  port_vec_t               port_gnt;
  bus_rsp_t                rsp;
  logic                    tgt_req;
  bus_cmd_t                tgt_cmd;
  logic                    tgt_ack;
  bus_data_t               tgt_rdata;

  integer seed = 85;

  // target memory and the shadow copy that expected read data comes from
  bus_data_t tgt_mem    [MemWords];
  bus_data_t shadow_mem [MemWords];

  // scoreboard state, updated by the monitor on the falling edge
  port_vec_t   gnt_seen;
  port_idx_t   last_served;
  port_idx_t   pend_port;
  bus_cmd_t    pend_cmd;
  int unsigned gnt_cnt;
  int unsigned rsp_cnt;
  int unsigned err_cnt;
  int unsigned test_cnt;
  int unsigned test_fail_cnt;
  int unsigned test_err_base;

  arb_top arb_top_inst (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .port_req_i  (port_req),
    .port_cmd_i  (port_cmd),
    .port_gnt_o  (port_gnt),
    .rsp_o       (rsp),
    .tgt_req_o   (tgt_req),
    .tgt_cmd_o   (tgt_cmd),
    .tgt_ack_i   (tgt_ack),
    .tgt_rdata_i (tgt_rdata)
  );

  bind arb_top arb_assertions assertions_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .port_req_i  (port_req_i),
    .port_gnt_i  (port_gnt_o),
    .rsp_i       (rsp_o),
    .tgt_req_i   (tgt_req_o),
    .tgt_cmd_i   (tgt_cmd_o),
    .tgt_ack_i   (tgt_ack_i)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // power-up contents, every address bit shows in the word
  function automatic bus_data_t fill_word(input bus_addr_t addr);
    return bus_data_t'({~addr, addr});
  endfunction

  // next requesting index above the last one served, wrapping around
  function automatic port_idx_t next_port(input port_idx_t last, input port_vec_t reqs);
    port_idx_t p;
    for (int i = 1; i <= NumPorts; i++) begin
      p = port_idx_t'((int'(last) + i) % NumPorts);
      if (reqs[p]) begin
        return p;
      end
    end
    return last;
  endfunction

  function automatic bus_cmd_t random_cmd();
    bus_cmd_t cmd;
    cmd.we    = 1'($random(seed));
    // a narrow address window so reads often hit earlier writes
    cmd.addr  = bus_addr_t'($random(seed) & 32'h7);
    cmd.wdata = bus_data_t'($random(seed));
    return cmd;
  endfunction

  function automatic int unsigned total_errors();
    return err_cnt + arb_top_inst.assertions_inst.fail_cnt;
  endfunction

  task automatic note_mismatch(input string what, input int unsigned got,
                               input int unsigned exp);
    $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
    err_cnt++;
  endtask

  task automatic end_test(input string name);
    int unsigned errs;
    errs = total_errors() - test_err_base;
    test_cnt++;
    if (errs != 0) begin
      test_fail_cnt++;
    end
    $display("test %s %s, %0d errors", name, (errs == 0) ? "pass" : "fail", errs);
    test_err_base = total_errors();
  endtask

  // ports in mask request back to back until the given number of grants
  task automatic run_traffic(input port_vec_t mask, input int unsigned grants);
    int unsigned stop_at;
    stop_at = gnt_cnt + grants;
    for (int p = 0; p < NumPorts; p++) begin
      if (mask[p]) begin
        port_cmd[p] = random_cmd();
      end
    end
    port_req = mask;
    while (gnt_cnt < stop_at) begin
      @(posedge clk);
      #2;
      for (int p = 0; p < NumPorts; p++) begin
        if (gnt_seen[p] && gnt_cnt < stop_at) begin
          port_cmd[p] = random_cmd();
        end
      end
    end
    port_req = '0;
    // wait for the last access to come back
    while (rsp_cnt != gnt_cnt) begin
      @(posedge clk);
      #2;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor and target model
  ////////////////////////////////////////////////////////////////////////////

  // inputs settle 2 ns after the rising edge, so the falling edge sees
  // exactly what the next rising edge will capture
  always @(negedge clk) begin
    port_idx_t idx;
    port_idx_t exp_idx;
    gnt_seen = port_gnt;
    if (rst_n && |port_gnt) begin
      idx = '0;
      for (int p = 0; p < NumPorts; p++) begin
        if (port_gnt[p]) begin
          idx = port_idx_t'(p);
        end
      end
      exp_idx = next_port(last_served, port_req);
      assert (idx == exp_idx) else note_mismatch("granted port", idx, exp_idx);
      last_served = idx;
      pend_port   = idx;
      pend_cmd    = port_cmd[idx];
      gnt_cnt++;
    end
    if (rst_n && |rsp.valid) begin
      assert (rsp.valid == (port_vec_t'(1) << pend_port))
        else note_mismatch("response strobe", rsp.valid, port_vec_t'(1) << pend_port);
      if (pend_cmd.we) begin
        shadow_mem[pend_cmd.addr] = pend_cmd.wdata;
      end else begin
        assert (rsp.rdata == shadow_mem[pend_cmd.addr])
          else note_mismatch("read data", rsp.rdata, shadow_mem[pend_cmd.addr]);
      end
      rsp_cnt++;
    end
  end

  // slow memory target, ack comes one to four cycles after req
  initial begin : target_model
    int unsigned delay;
    forever begin
      @(negedge clk);
      if (tgt_req && !tgt_ack) begin
        // the port presents the command of the requester it granted
        assert (tgt_cmd == pend_cmd)
          else note_mismatch("target command", tgt_cmd, pend_cmd);
        delay = 1 + ($random(seed) & 3);
        repeat (delay) @(posedge clk);
        #2;
        if (tgt_cmd.we) begin
          tgt_mem[tgt_cmd.addr] = tgt_cmd.wdata;
        end
        tgt_rdata = tgt_mem[tgt_cmd.addr];
        tgt_ack   = 1'b1;
        // ack stays up until the port has dropped its request
        do begin
          @(negedge clk);
        end while (tgt_req);
        @(posedge clk);
        #2;
        tgt_ack = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    port_req      = '0;
    port_cmd      = '0;
    tgt_ack       = 1'b0;
    tgt_rdata     = '0;
    gnt_seen      = '0;
    // the priority starts at port 0, as if port 3 had been served last
    last_served   = port_idx_t'(NumPorts - 1);
    pend_port     = '0;
    pend_cmd      = '0;
    gnt_cnt       = 0;
    rsp_cnt       = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    test_err_base = 0;
    for (int a = 0; a < MemWords; a++) begin
      tgt_mem[a]    = fill_word(bus_addr_t'(a));
      shadow_mem[a] = fill_word(bus_addr_t'(a));
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    assert (tgt_req == 1'b0) else note_mismatch("tgt_req in reset", tgt_req, 0);
    assert (rsp.valid == '0) else note_mismatch("rsp valid in reset", rsp.valid, 0);
    assert (port_gnt == '0) else note_mismatch("grant in reset", port_gnt, 0);
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    end_test("reset");

    // all ports request from the first cycle out of reset
    run_traffic('1, 12);
    end_test("saturation");

    run_traffic(port_vec_t'(4'b0101), 8);
    end_test("sparse");

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail_cnt,
             total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // each test gets at most 200 clock cycles
  initial begin
    #(NumTests * 200 * ClkPeriod);
    $display("timeout: traffic did not complete within %0d cycles", NumTests * 200);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/arb_cfg_pkg.sv
logic/bus_pkg.sv
logic/lzc.sv
logic/rr_arb_tree.sv
logic/fourphase_port.sv
logic/arb_top.sv
test/arb_assertions.sv
test/tb_arb_top.sv

//--- Makefile
# Verilator build and run for the shared-target arbiter
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_arb_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS  ?= +verilator+error+limit+1000
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
